// ==== all.f ====
+incdir+hdl
hdl/id_pkg.sv
hdl/id_stage_reg.sv
hdl/inst_decoder.sv
hdl/operand_issue.sv
hdl/id_top.sv
tb/tb_clock.sv
tb/tb_checker.sv
tb/tb_top.sv

// ==== run.sh ====
#!/bin/sh
# build the decode stage testbench with Verilator and run it
verilator --binary --timing --assert -f all.f --top-module tb_top -o tb_sim \
    && ./obj_dir/tb_sim | awk '{ print } /^test passed$/ { ok = 1 } END { exit !ok }' \
    && echo "run.sh: simulation ok" \
    || { echo "run.sh: simulation failed"; exit 1; }

// ==== tb/tb_top.sv ====
// testbench top for the decode stage, drives random fetch traffic and gives the verdict
`default_nettype none
`timescale 1ns/100ps

`include "id_consts.svh"

module tb_top;
    import id_pkg::*;

    localparam int n_inst     = 600;
    localparam int clk_ns     = 4;
    localparam int drive_dly  = 1;
    localparam int max_cycles = 20;    // per instruction

    logic                               clk;
    logic                               rst;
    logic                               in_valid;
    logic                               in_ready;
    fetch_t                             in_fetch;
    reg_idx_t                           rs1_addr;
    reg_idx_t                           rs2_addr;
    xlen_t                              rs1_data;
    xlen_t                              rs2_data;
    logic [`ID_NREGS-1:0]               gpr_busy;
    logic                               out_valid;
    logic                               out_ready;
    issue_t                             out_issue;
    logic [`ID_NREGS-1:0][`ID_XLEN-1:0] regs;
    logic [31:0]                        lfsr = 32'd66327;
    int                                 err_count;
    int                                 n_in;
    int                                 n_out;
    int                                 sent;
    logic                               held_offer;

    assign rs1_data = regs[rs1_addr];    // register file answers in the same cycle
    assign rs2_data = regs[rs2_addr];

    tb_clock clock_i (
        .clk (clk),
        .rst (rst)
    );

    id_top dut_i (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_fetch  (in_fetch),
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .gpr_busy  (gpr_busy),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_issue (out_issue)
    );

    tb_checker check_i (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_fetch  (in_fetch),
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .gpr_busy  (gpr_busy),
        .regs      (regs),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_issue (out_issue),
        .err_count (err_count),
        .n_in      (n_in),
        .n_out     (n_out)
    );

    // galois lfsr, x^32 + x^22 + x^2 + x + 1
    function automatic logic next_bit();
        logic b;
        b    = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) begin
            lfsr = lfsr ^ 32'h8020_0003;
        end
        return b;
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[62:0], next_bit()};
        end
        return v;
    endfunction

    // legal encodings with random fields, near misses and raw words
    function automatic logic [31:0] make_inst();
        logic [31:0] w;
        logic [3:0]  kind;
        logic [2:0]  f3;
        w    = 32'(rand_bits(32));
        kind = 4'(rand_bits(4));
        f3   = w[14:12];
        case (kind)
            4'd0: w[6:0] = `ID_OPC_LUI;
            4'd1: w[6:0] = `ID_OPC_AUIPC;
            4'd2: w[6:0] = `ID_OPC_JAL;
            4'd3: begin
                w[6:0]   = `ID_OPC_JALR;
                w[14:12] = 3'd0;
            end
            4'd4: begin
                w[6:0] = `ID_OPC_BRANCH;
                w[14]  = w[14] || f3[2:1] == 2'b01;    // skip codes 2 and 3
            end
            4'd5: begin
                w[6:0] = `ID_OPC_LOAD;
                w[12]  = w[12] && f3 != 3'd7;
            end
            4'd6: begin
                w[6:0] = `ID_OPC_STORE;
                w[14]  = 1'b0;
            end
            4'd7: begin
                w[6:0] = `ID_OPC_OPIMM;
                if (f3 == 3'd1 || f3 == 3'd5) begin
                    w[31:26] = {1'b0, w[30] && f3 == 3'd5, 4'b0};
                end
            end
            4'd8: begin
                w[6:0]   = `ID_OPC_OP;
                w[31:25] = {1'b0, w[30] && (f3 == 3'd0 || f3 == 3'd5), 5'b0};
            end
            4'd9: begin
                w[6:0]   = `ID_OPC_OPIMM32;
                w[14:12] = 3'd0;
            end
            4'd10: w[6:0] = `ID_OPC_OPIMM32;    // mostly the dropped w forms
            4'd11: w[6:0] = `ID_OPC_OP;         // random funct7
            4'd12: w[6:0] = `ID_OPC_OPIMM;      // random shift funct6
            default: ;
        endcase
        return w;
    endfunction

    task automatic drive_controls();
        out_ready = rand_bits(2) != 64'd0;
        for (int r = 0; r < `ID_NREGS; r++) begin
            gpr_busy[r] = rand_bits(2) == 64'd0;    // about a quarter busy
        end
    endtask

    initial begin
        in_valid  = 1'b0;
        in_fetch  = '0;
        out_ready = 1'b0;
        gpr_busy  = '0;
        sent      = 0;
        for (int r = 0; r < `ID_NREGS; r++) begin
            regs[r] = (r == 0) ? 64'd0 : rand_bits(64);
        end
        @(negedge rst);
        while (sent < n_inst) begin
            @(negedge clk);
            held_offer = in_valid && !in_ready;    // offer stays until taken
            if (in_valid && in_ready) begin
                sent++;
            end
            @(posedge clk);
            #(drive_dly);
            drive_controls();
            if (!held_offer) begin
                in_valid = sent < n_inst && rand_bits(2) != 64'd0;
                if (in_valid) begin
                    in_fetch.pc       = rand_bits(62) << 2;
                    in_fetch.inst.raw = make_inst();
                end
            end
        end
        while (n_out < n_inst) begin
            @(posedge clk);
            #(drive_dly);
            drive_controls();
        end
        repeat (4) @(posedge clk);
        $display("closing: %0d accepted, %0d issued, %0d errors", n_in, n_out, err_count);
        if (err_count == 0 && n_in == n_inst) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        #(n_inst * max_cycles * clk_ns);
        $display("timeout: only %0d of %0d instructions issued", n_out, n_inst);
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/tb_checker.sv ====
// monitor for the decode stage, models both stages per cycle and compares the ports
`default_nettype none
`timescale 1ns/100ps

`include "id_consts.svh"

module tb_checker (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               in_valid,
    input  logic                               in_ready,
    input  id_pkg::fetch_t                     in_fetch,
    input  id_pkg::reg_idx_t                   rs1_addr,
    input  id_pkg::reg_idx_t                   rs2_addr,
    input  logic [`ID_NREGS-1:0]               gpr_busy,
    input  logic [`ID_NREGS-1:0][`ID_XLEN-1:0] regs,
    input  logic                               out_valid,
    input  logic                               out_ready,
    input  id_pkg::issue_t                     out_issue,
    output int                                 err_count,
    output int                                 n_in,
    output int                                 n_out
);
    import id_pkg::*;

    localparam logic [7:0] base_mode [8] = '{`ID_ALU_ADD, `ID_ALU_SLL, `ID_ALU_SLT,
        `ID_ALU_SLTU, `ID_ALU_XOR, `ID_ALU_SRL, `ID_ALU_OR, `ID_ALU_AND};

    logic   a_valid;      // decode slot
    fetch_t a_fetch;
    logic   b_valid;      // issue slot
    issue_t b_exp;
    issue_t a_exp;
    logic   use1;
    logic   use2;
    logic   stall;
    logic   adv;
    logic   exp_ready;
    logic   hold_last;
    issue_t last_issue;

    initial begin
        err_count = 0;
        n_in      = 0;
        n_out     = 0;
    end

    task automatic check_val(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
        if (got !== exp) begin
            err_count++;
            $display("error %s got %h expected %h at %0t ns", name, got, exp, $time);
        end
    endtask

    task automatic compare_issue(input issue_t got, input issue_t exp);
        check_val("out_issue.pc", got.pc, exp.pc);
        check_val("out_issue.op_class", 64'(got.op_class), 64'(exp.op_class));
        check_val("out_issue.funct3", 64'(got.funct3), 64'(exp.funct3));
        check_val("out_issue.alu_mode", 64'(got.alu_mode), 64'(exp.alu_mode));
        check_val("out_issue.opa", got.opa, exp.opa);
        check_val("out_issue.opb", got.opb, exp.opb);
        check_val("out_issue.store_data", got.store_data, exp.store_data);
        check_val("out_issue.rd", 64'(got.rd), 64'(exp.rd));
        check_val("out_issue.wen", 64'(got.wen), 64'(exp.wen));
    endtask

    // reference decode straight from the instruction bits
    function automatic issue_t expect_issue(input fetch_t f, output logic u1, output logic u2);
        logic [31:0] w;
        logic [2:0]  f3;
        logic [63:0] src1;
        logic [63:0] src2;
        logic [63:0] imm_i;
        logic        shift;
        issue_t      e;
        w            = f.inst.raw;
        f3           = w[14:12];
        src1         = regs[w[19:15]];
        src2         = regs[w[24:20]];
        imm_i        = {{52{w[31]}}, w[31:20]};
        shift        = f3 == 3'd1 || f3 == 3'd5;
        e            = '0;
        e.pc         = f.pc;
        e.op_class   = op_illegal;
        e.alu_mode   = `ID_ALU_ADD;
        e.store_data = src2;
        u1           = 1'b0;
        u2           = 1'b0;
        case (w[6:0])
            `ID_OPC_LUI: begin
                e.op_class = op_lui;
                e.opa      = {{32{w[31]}}, w[31:12], 12'h000};
            end
            `ID_OPC_AUIPC: begin
                e.op_class = op_auipc;
                e.opa      = f.pc;
                e.opb      = {{32{w[31]}}, w[31:12], 12'h000};
            end
            `ID_OPC_JAL: begin
                e.op_class = op_jal;
                e.opa      = f.pc;
                e.opb      = {{44{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            end
            `ID_OPC_JALR, `ID_OPC_LOAD, `ID_OPC_OPIMM32: begin
                if (w[6:0] == `ID_OPC_LOAD && f3 != 3'd7) begin
                    e.op_class = op_load;
                end else if (w[6:0] == `ID_OPC_JALR && f3 == 3'd0) begin
                    e.op_class = op_jalr;
                end else if (w[6:0] == `ID_OPC_OPIMM32 && f3 == 3'd0) begin
                    e.op_class = op_alu;    // addiw
                end
                if (e.op_class != op_illegal) begin
                    e.funct3 = f3;
                    e.opa    = src1;
                    e.opb    = imm_i;
                    u1       = 1'b1;
                end
            end
            `ID_OPC_STORE: begin
                if (!f3[2]) begin
                    e.op_class = op_store;
                    e.funct3   = f3;
                    e.opa      = src1;
                    e.opb      = {{52{w[31]}}, w[31:25], w[11:7]};
                    u1         = 1'b1;
                    u2         = 1'b1;
                end
            end
            `ID_OPC_BRANCH: begin
                if (f3 != 3'd2 && f3 != 3'd3) begin
                    e.op_class = op_branch;
                    e.funct3   = f3;
                    e.alu_mode = `ID_ALU_SUB;
                    e.opa      = src1;
                    e.opb      = src2;
                    u1         = 1'b1;
                    u2         = 1'b1;
                end
            end
            `ID_OPC_OPIMM: begin
                if (!shift || w[31:26] == 6'd0 || (f3 == 3'd5 && w[31:26] == 6'b010000)) begin
                    e.op_class = op_alu;
                    e.funct3   = f3;
                    e.alu_mode = (f3 == 3'd5 && w[30]) ? `ID_ALU_SRA : base_mode[f3];
                    e.opa      = src1;
                    e.opb      = shift ? {58'd0, w[25:20]} : imm_i;
                    u1         = 1'b1;
                end
            end
            `ID_OPC_OP: begin
                if (w[31:25] == 7'd0 ||
                    (w[31:25] == 7'b0100000 && (f3 == 3'd0 || f3 == 3'd5))) begin
                    e.op_class = op_alu;
                    e.funct3   = f3;
                    e.alu_mode = base_mode[f3];
                    if (w[30]) begin
                        e.alu_mode = (f3 == 3'd0) ? `ID_ALU_SUB : `ID_ALU_SRA;
                    end
                    e.opa = src1;
                    e.opb = shift ? {58'd0, src2[5:0]} : src2;
                    u1    = 1'b1;
                    u2    = 1'b1;
                end
            end
            default: ;
        endcase
        e.wen = e.op_class inside {op_alu, op_load, op_jal, op_jalr, op_lui, op_auipc};
        e.rd  = e.wen ? w[11:7] : 5'd0;
        return e;
    endfunction

    // inputs settle 1 ns after the rising edge, so the falling edge sees the edge values
    always @(negedge clk) begin
        if (rst) begin
            a_valid   = 1'b0;
            b_valid   = 1'b0;
            hold_last = 1'b0;
        end else begin
            a_exp     = expect_issue(a_fetch, use1, use2);
            stall     = (use1 && gpr_busy[a_fetch.inst.raw[19:15]]) ||
                        (use2 && gpr_busy[a_fetch.inst.raw[24:20]]);
            adv       = a_valid && !stall && (!b_valid || out_ready);
            exp_ready = !a_valid || adv;
            check_val("in_ready", 64'(in_ready), 64'(exp_ready));
            check_val("out_valid", 64'(out_valid), 64'(b_valid));
            if (a_valid) begin
                check_val("rs1_addr", 64'(rs1_addr), 64'(a_fetch.inst.raw[19:15]));
                check_val("rs2_addr", 64'(rs2_addr), 64'(a_fetch.inst.raw[24:20]));
            end
            if (hold_last && out_issue !== last_issue) begin
                err_count++;
                $display("error out_issue changed under back-pressure got %h expected %h",
                         out_issue, last_issue);
            end
            if (b_valid && out_valid && out_ready) begin
                compare_issue(out_issue, b_exp);
                n_out++;
            end
            hold_last  = out_valid && !out_ready;
            last_issue = out_issue;
            // state after the coming edge
            if (in_valid && exp_ready) begin
                n_in++;
            end
            if (adv) begin
                b_valid = 1'b1;
                b_exp   = a_exp;
            end else if (out_ready) begin
                b_valid = 1'b0;
            end
            if (exp_ready) begin
                a_valid = in_valid;
                a_fetch = in_fetch;
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb/tb_clock.sv ====
// clock and reset source for the decode stage testbench, instanced once in tb_top
`default_nettype none
`timescale 1ns/100ps

module tb_clock #(
    parameter int half_period = 2,
    parameter int rst_cycles  = 8
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (rst_cycles) @(posedge clk);
        #1 rst = 1'b0;    // released with the other inputs
    end

endmodule

`default_nettype wire

// ==== hdl/id_top.sv ====
// decode stage top level connecting the decode register, decoder and issue block
`default_nettype none
`timescale 1ns/100ps

`include "id_consts.svh"

module id_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  id_pkg::fetch_t       in_fetch,
    output id_pkg::reg_idx_t     rs1_addr,
    output id_pkg::reg_idx_t     rs2_addr,
    input  id_pkg::xlen_t        rs1_data,
    input  id_pkg::xlen_t        rs2_data,
    input  logic [`ID_NREGS-1:0] gpr_busy,
    output logic                 out_valid,
    input  logic                 out_ready,
    output id_pkg::issue_t       out_issue
);
    import id_pkg::*;

    logic   advance;
    logic   held_valid;
    fetch_t held;
    dec_t   dec;

    assign rs1_addr = held.inst.r.rs1;    // register file reads the held word
    assign rs2_addr = held.inst.r.rs2;

    id_stage_reg stage_i (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_fetch   (in_fetch),
        .advance    (advance),
        .held_valid (held_valid),
        .held       (held)
    );

    inst_decoder decode_i (
        .inst (held.inst),
        .dec  (dec)
    );

    operand_issue issue_i (
        .clk        (clk),
        .rst        (rst),
        .held_valid (held_valid),
        .held       (held),
        .dec        (dec),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .gpr_busy   (gpr_busy),
        .advance    (advance),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_issue  (out_issue)
    );

endmodule

`default_nettype wire

// ==== hdl/operand_issue.sv ====
// scoreboard stall check, operand muxing and the issue register feeding execute
`default_nettype none
`timescale 1ns/100ps

`include "id_consts.svh"

module operand_issue (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 held_valid,
    input  id_pkg::fetch_t       held,
    input  id_pkg::dec_t         dec,
    input  id_pkg::xlen_t        rs1_data,
    input  id_pkg::xlen_t        rs2_data,
    input  logic [`ID_NREGS-1:0] gpr_busy,
    output logic                 advance,
    output logic                 out_valid,
    input  logic                 out_ready,
    output id_pkg::issue_t       out_issue
);
    import id_pkg::*;

    logic   stall;
    xlen_t  opa;
    xlen_t  opb;
    issue_t nxt;

    assign stall = (dec.use_rs1 && gpr_busy[held.inst.r.rs1]) ||
                   (dec.use_rs2 && gpr_busy[held.inst.r.rs2]);
    assign advance = held_valid && !stall && (!out_valid || out_ready);

    always_comb begin
        case (dec.opa_sel)
            opa_rs1: opa = rs1_data;
            opa_pc:  opa = held.pc;    // pc of this instruction
            opa_imm: opa = dec.imm;
            default: opa = '0;
        endcase
        case (dec.opb_sel)
            opb_rs2:   opb = rs2_data;
            opb_shamt: opb = xlen_t'(rs2_data[`ID_SHAMT_W-1:0]);
            opb_imm:   opb = dec.imm;
            default:   opb = '0;
        endcase
    end

    always_comb begin
        nxt.pc         = held.pc;
        nxt.op_class   = dec.op_class;
        nxt.funct3     = dec.funct3;
        nxt.alu_mode   = dec.alu_mode;
        nxt.opa        = opa;
        nxt.opb        = opb;
        nxt.store_data = rs2_data;
        nxt.rd         = dec.rd;
        nxt.wen        = dec.wen;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (advance) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;    // drained with nothing behind it
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            out_issue <= nxt;
        end
    end

    a_hold_under_backpressure: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_issue));

endmodule

`default_nettype wire

// ==== hdl/inst_decoder.sv ====
// combinational RV64I decoder turning the held instruction word into a decode bundle
`default_nettype none
`timescale 1ns/100ps

`include "id_consts.svh"

module inst_decoder (
    input  id_pkg::inst_u inst,
    output id_pkg::dec_t  dec
);
    import id_pkg::*;

    logic [2:0]                f3;
    logic [5:0]                funct6;
    logic                      shift_f3;
    logic                      is_op;       // register-register form
    op_class_e                 cls;
    logic [`ID_ALU_MODE_W-1:0] mode;
    xlen_t                     imm_i;
    xlen_t                     imm_s;
    xlen_t                     imm_b;
    xlen_t                     imm_u;
    xlen_t                     imm_j;
    xlen_t                     imm_sh;

    function automatic logic [`ID_ALU_MODE_W-1:0] alu_mode_of(input logic [2:0] funct3,
                                                              input logic       alt);
        case (funct3)
            3'd0:    return alt ? `ID_ALU_SUB : `ID_ALU_ADD;
            3'd1:    return `ID_ALU_SLL;
            3'd2:    return `ID_ALU_SLT;
            3'd3:    return `ID_ALU_SLTU;
            3'd4:    return `ID_ALU_XOR;
            3'd5:    return alt ? `ID_ALU_SRA : `ID_ALU_SRL;
            3'd6:    return `ID_ALU_OR;
            default: return `ID_ALU_AND;
        endcase
    endfunction

    assign f3       = inst.r.funct3;
    assign funct6   = inst.i.imm_11_0[11:`ID_SHAMT_W];
    assign shift_f3 = f3[1:0] == 2'b01;    // sll, srl, sra

    assign imm_i  = xlen_t'($signed(inst.i.imm_11_0));
    assign imm_s  = xlen_t'($signed({inst.s.imm_11_5, inst.s.imm_4_0}));
    assign imm_b  = xlen_t'($signed({inst.b.imm_12, inst.b.imm_11, inst.b.imm_10_5,
                                     inst.b.imm_4_1, 1'b0}));
    assign imm_u  = xlen_t'($signed({inst.u.imm_31_12, 12'b0}));
    assign imm_j  = xlen_t'($signed({inst.j.imm_20, inst.j.imm_19_12, inst.j.imm_11,
                                     inst.j.imm_10_1, 1'b0}));
    assign imm_sh = xlen_t'(inst.i.imm_11_0[`ID_SHAMT_W-1:0]);

    always_comb begin
        cls   = op_illegal;
        mode  = `ID_ALU_ADD;
        is_op = 1'b0;
        case (inst.r.opcode)
            `ID_OPC_LUI:   cls = op_lui;
            `ID_OPC_AUIPC: cls = op_auipc;
            `ID_OPC_JAL:   cls = op_jal;
            `ID_OPC_JALR:  cls = (f3 == 3'd0) ? op_jalr : op_illegal;
            `ID_OPC_LOAD:  cls = (f3 != 3'd7) ? op_load : op_illegal;    // lb..ld, lbu..lwu
            `ID_OPC_STORE: cls = !f3[2] ? op_store : op_illegal;
            `ID_OPC_BRANCH: begin
                if (f3[2:1] != 2'b01) begin
                    cls  = op_branch;
                    mode = `ID_ALU_SUB;
                end
            end
            `ID_OPC_OPIMM: begin
                if (!shift_f3 || funct6 == 6'b000000 || (f3 == 3'd5 && funct6 == 6'b010000)) begin
                    cls  = op_alu;
                    mode = alu_mode_of(f3, shift_f3 && funct6[4]);
                end
            end
            `ID_OPC_OP: begin
                if (inst.r.funct7 == 7'b0 ||
                    (inst.r.funct7 == 7'b0100000 && (f3 == 3'd0 || f3 == 3'd5))) begin
                    cls   = op_alu;
                    is_op = 1'b1;
                    mode  = alu_mode_of(f3, inst.r.funct7[5]);
                end
            end
            `ID_OPC_OPIMM32: cls = (f3 == 3'd0) ? op_alu : op_illegal;    // addiw only
            default: ;
        endcase
    end

    always_comb begin
        dec.op_class = cls;
        dec.alu_mode = mode;
        dec.funct3   = f3;
        dec.opa_sel  = opa_rs1;
        dec.opb_sel  = opb_imm;
        dec.imm      = imm_i;
        dec.use_rs1  = 1'b1;
        dec.use_rs2  = 1'b0;
        case (cls)
            op_lui, op_auipc, op_jal: begin
                dec.funct3  = 3'd0;
                dec.opa_sel = (cls == op_lui) ? opa_imm : opa_pc;
                dec.opb_sel = (cls == op_lui) ? opb_zero : opb_imm;
                dec.imm     = (cls == op_jal) ? imm_j : imm_u;
                dec.use_rs1 = 1'b0;
            end
            op_branch: begin
                dec.opb_sel = opb_rs2;
                dec.imm     = imm_b;    // branch offset for execute
                dec.use_rs2 = 1'b1;
            end
            op_store: begin
                dec.imm     = imm_s;
                dec.use_rs2 = 1'b1;
            end
            op_alu: begin
                dec.opb_sel = is_op ? (shift_f3 ? opb_shamt : opb_rs2) : opb_imm;
                dec.imm     = is_op ? '0 : (shift_f3 ? imm_sh : imm_i);
                dec.use_rs2 = is_op;
            end
            op_illegal: begin
                dec.funct3  = 3'd0;
                dec.opa_sel = opa_zero;
                dec.opb_sel = opb_zero;
                dec.imm     = '0;
                dec.use_rs1 = 1'b0;
            end
            default: ;    // jalr and loads keep rs1 + imm_i
        endcase
        dec.wen = !(cls inside {op_branch, op_store, op_illegal});
        dec.rd  = dec.wen ? inst.r.rd : '0;
    end

endmodule

`default_nettype wire

// ==== hdl/id_stage_reg.sv ====
// decode register holding one fetched instruction, loaded under the fetch valid/ready handshake
`default_nettype none
`timescale 1ns/100ps

module id_stage_reg (
    input  logic           clk,
    input  logic           rst,
    input  logic           in_valid,
    output logic           in_ready,
    input  id_pkg::fetch_t in_fetch,
    input  logic           advance,
    output logic           held_valid,
    output id_pkg::fetch_t held
);

    assign in_ready = !held_valid || advance;    // empty or leaving this cycle

    always_ff @(posedge clk) begin
        if (rst) begin
            held_valid <= 1'b0;
        end else if (in_ready) begin
            held_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            held <= in_fetch;
        end
    end

    // a waiting instruction survives until operand_issue takes it
    a_no_overwrite: assert property (@(posedge clk) disable iff (rst)
        held_valid && !advance |=> held_valid && $stable(held));

endmodule

`default_nettype wire

// ==== hdl/id_pkg.sv ====
// instruction formats and stage bundles of the decode stage, imported by its modules
`default_nettype none

`include "id_consts.svh"

package id_pkg;

    typedef logic [`ID_XLEN-1:0] xlen_t;
    typedef logic [4:0]          reg_idx_t;

    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;    // shamt in the low bits for shifts
        reg_idx_t    rs1;
        logic [2:0]  funct3;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        logic [31:0] raw;
        r_fmt_t      r;
        i_fmt_t      i;
        s_fmt_t      s;
        b_fmt_t      b;
        u_fmt_t      u;
        j_fmt_t      j;
    } inst_u;

    typedef enum logic [3:0] {
        op_alu, op_branch, op_load, op_store, op_jal, op_jalr, op_lui, op_auipc, op_illegal
    } op_class_e;

    typedef enum logic [1:0] {opa_zero, opa_rs1, opa_pc, opa_imm} opa_sel_e;
    typedef enum logic [1:0] {opb_zero, opb_rs2, opb_shamt, opb_imm} opb_sel_e;

    typedef struct packed {
        xlen_t pc;
        inst_u inst;
    } fetch_t;

    typedef struct packed {
        op_class_e                 op_class;
        logic [2:0]                funct3;
        logic [`ID_ALU_MODE_W-1:0] alu_mode;
        opa_sel_e                  opa_sel;
        opb_sel_e                  opb_sel;
        xlen_t                     imm;       // sign-extended
        logic                      use_rs1;
        logic                      use_rs2;
        reg_idx_t                  rd;
        logic                      wen;
    } dec_t;

    typedef struct packed {
        xlen_t                     pc;
        op_class_e                 op_class;
        logic [2:0]                funct3;
        logic [`ID_ALU_MODE_W-1:0] alu_mode;
        xlen_t                     opa;
        xlen_t                     opb;
        xlen_t                     store_data;
        reg_idx_t                  rd;
        logic                      wen;
    } issue_t;

endpackage

`default_nettype wire

// ==== hdl/id_consts.svh ====
// widths, major opcodes and alu mode codes for the decode stage, include where needed
`ifndef ID_CONSTS_SVH
`define ID_CONSTS_SVH

`define ID_XLEN        64
`define ID_NREGS       32
`define ID_SHAMT_W     6
`define ID_ALU_MODE_W  8

`define ID_OPC_LUI     7'b0110111
`define ID_OPC_AUIPC   7'b0010111
`define ID_OPC_JAL     7'b1101111
`define ID_OPC_JALR    7'b1100111
`define ID_OPC_BRANCH  7'b1100011
`define ID_OPC_LOAD    7'b0000011
`define ID_OPC_STORE   7'b0100011
`define ID_OPC_OPIMM   7'b0010011
`define ID_OPC_OP      7'b0110011
`define ID_OPC_OPIMM32 7'b0011011

`define ID_ALU_ADD     8'd0
`define ID_ALU_SUB     8'd1
`define ID_ALU_SLT     8'd2
`define ID_ALU_SLTU    8'd3
`define ID_ALU_AND     8'd4
`define ID_ALU_OR      8'd6
`define ID_ALU_XOR     8'd7
`define ID_ALU_SLL     8'd8
`define ID_ALU_SRL     8'd9
`define ID_ALU_SRA     8'd10

`endif
